// ==== rtl/gc_pkg.sv ====
package gc_pkg;

    //////////////////////////////
    // Widths

    // Instruction id, up to eight in flight
    localparam int ID_W = 3;

    // PCs and trap values
    localparam int XLEN = 32;

    //////////////////////////////
    // Issue operations

    // Only the ops the control unit reacts to
    typedef enum logic [1:0] {
        OP_NORMAL  = 2'd0,
        OP_FENCE_I = 2'd1,
        OP_MRET    = 2'd2,
        OP_SFENCE  = 2'd3
    } gc_op_t;

    //////////////////////////////
    // Exception causes

    // Encodings follow the mcause values
    typedef enum logic [3:0] {
        EXC_INSTR_MISALIGNED = 4'd0,
        EXC_ILLEGAL          = 4'd2,
        EXC_LOAD_MISALIGNED  = 4'd4,
        EXC_STORE_MISALIGNED = 4'd6,
        EXC_ECALL            = 4'd11
    } exc_code_t;

    //////////////////////////////
    // Control states

    typedef enum logic [2:0] {
        ST_RESET,
        ST_PRE_CLEAR,
        ST_INIT_CLEAR,
        ST_IDLE,
        ST_TLB_CLEAR,
        ST_DRAIN,
        ST_DISCARD
    } gc_state_t;

endpackage

// ==== rtl/inflight_tracker.sv ====
module inflight_tracker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  logic [gc_pkg::XLEN-1:0]   issue_pc,
    input  logic                      retire,
    output logic [gc_pkg::ID_W-1:0]   next_id,
    output logic [gc_pkg::ID_W-1:0]   oldest_id,
    output logic [gc_pkg::XLEN-1:0]   oldest_pc,
    output logic [gc_pkg::ID_W:0]     inflight_count
);

    localparam int DEPTH = 2 ** gc_pkg::ID_W;

    // PC of every id in flight
    logic [gc_pkg::XLEN-1:0] pc_ring [DEPTH];
    logic [gc_pkg::ID_W-1:0] issue_ptr;
    logic [gc_pkg::ID_W-1:0] retire_ptr;

    //////////////////////////////
    // Pointers and count

    // Ids handed out and retired in order, pointers wrap
    always_ff @(posedge clk) begin
        if (rst) begin
            issue_ptr      <= '0;
            retire_ptr     <= '0;
            inflight_count <= '0;
        end else begin
            if (issue_valid)
                issue_ptr <= issue_ptr + 1'b1;
            if (retire)
                retire_ptr <= retire_ptr + 1'b1;
            // Issue and retire together leave the count alone
            case ({issue_valid, retire})
                2'b10:   inflight_count <= inflight_count + 1'b1;
                2'b01:   inflight_count <= inflight_count - 1'b1;
                default: inflight_count <= inflight_count;
            endcase
        end
    end

    // Issue PC capture
    always_ff @(posedge clk) begin
        if (issue_valid)
            pc_ring[issue_ptr] <= issue_pc;
    end

    assign next_id   = issue_ptr;
    assign oldest_id = retire_ptr;
    assign oldest_pc = pc_ring[retire_ptr];

    //////////////////////////////
    // Checks

    // Retire with nothing in flight
    retire_empty_a: assert property (@(posedge clk) disable iff (rst)
        retire |-> inflight_count != '0)
        else $error("retire with empty pipeline");

    // Ninth issue only legal if a slot frees the same cycle
    issue_full_a: assert property (@(posedge clk) disable iff (rst)
        issue_valid && inflight_count[gc_pkg::ID_W] |-> retire)
        else $error("issue with all ids in flight");

endmodule

// ==== rtl/exception_arbiter.sv ====
module exception_arbiter #(
    parameter int NUM_EXC_SOURCES = 2
) (
    input  logic                                             clk,
    input  logic                                             rst,
    input  logic [NUM_EXC_SOURCES-1:0]                       exc_valid,
    input  gc_pkg::exc_code_t [NUM_EXC_SOURCES-1:0]          exc_code,
    input  logic [NUM_EXC_SOURCES-1:0][gc_pkg::ID_W-1:0]     exc_id,
    input  logic [NUM_EXC_SOURCES-1:0][gc_pkg::XLEN-1:0]     exc_tval,
    input  logic [gc_pkg::ID_W-1:0]                          oldest_id,
    input  logic                                             exc_ack,
    output logic                                             sel_valid,
    output gc_pkg::exc_code_t                                sel_code,
    output logic [gc_pkg::XLEN-1:0]                          sel_tval
);

    // Sources whose pending exception belongs to the oldest id
    logic [NUM_EXC_SOURCES-1:0] id_match;

    //////////////////////////////
    // Id compare

    // One comparator per source, cheap at this source count
    generate
        for (genvar i = 0; i < NUM_EXC_SOURCES; i++) begin : g_match
            assign id_match[i] = exc_valid[i] && (exc_id[i] == oldest_id);
        end
    endgenerate

    //////////////////////////////
    // Selection

    // Lowest matching index wins
    // Walk from the top so the lowest hit is written last
    always_comb begin
        sel_valid = 1'b0;
        sel_code  = gc_pkg::EXC_ILLEGAL;
        sel_tval  = '0;
        for (int i = NUM_EXC_SOURCES - 1; i >= 0; i--) begin
            if (id_match[i]) begin
                sel_valid = 1'b1;
                sel_code  = exc_code[i];
                sel_tval  = exc_tval[i];
            end
        end
    end

    //////////////////////////////
    // Source protocol

    // Exception must stay raised and unchanged until the ack pulse
    // Ack comes from the control unit one cycle after the trap
    generate
        for (genvar i = 0; i < NUM_EXC_SOURCES; i++) begin : g_hold_chk
            exc_hold_a: assert property (@(posedge clk) disable iff (rst)
                exc_valid[i] && !exc_ack |=>
                    exc_ack || (exc_valid[i] && $stable(exc_id[i])
                                && $stable(exc_code[i]) && $stable(exc_tval[i])))
                else $error("source %0d dropped or changed exception before ack", i);
        end
    endgenerate

endmodule

// ==== rtl/gc_unit.sv ====
module gc_unit #(
    parameter int                      INIT_CLEAR_DEPTH = 64,
    parameter int                      TLB_CLEAR_DEPTH  = 16,
    parameter logic [gc_pkg::XLEN-1:0] RESET_VECTOR     = 32'h0000_0100
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  gc_pkg::gc_op_t            issue_op,
    input  logic [gc_pkg::XLEN-1:0]   issue_pc,
    input  logic [gc_pkg::XLEN-1:0]   epc,
    input  logic [gc_pkg::XLEN-1:0]   trap_vector,
    input  logic [gc_pkg::ID_W:0]     inflight_count,
    input  logic                      interrupt_pending,
    input  logic                      sel_valid,
    output logic                      fetch_hold,
    output logic                      issue_hold,
    output logic                      fetch_flush,
    output logic                      pc_override,
    output logic [gc_pkg::XLEN-1:0]   pc,
    output logic                      init_clear,
    output logic                      tlb_flush,
    output logic                      suppress_writeback,
    output logic                      trap_valid,
    output logic                      exc_ack,
    output logic                      mret,
    output logic                      interrupt_taken
);

    // Counter sized for the longer sweep
    localparam int MAX_DEPTH = (INIT_CLEAR_DEPTH > TLB_CLEAR_DEPTH) ?
                               INIT_CLEAR_DEPTH : TLB_CLEAR_DEPTH;
    localparam int CNT_W = $clog2(MAX_DEPTH) + 1;
    localparam logic [gc_pkg::XLEN-1:0] INSTR_BYTES = 4;

    gc_pkg::gc_state_t state;
    gc_pkg::gc_state_t next_state;

    logic [CNT_W-1:0] clear_cnt;
    logic             init_clear_done;
    logic             tlb_clear_done;
    logic             pipe_empty;
    logic             trap_window;
    logic             op_redirect;
    logic             op_sfence;
    logic             op_is_mret;

    //////////////////////////////
    // Issue decode

    // Only IDLE lets issue through, holds cover the rest
    assign op_is_mret  = issue_valid && (issue_op == gc_pkg::OP_MRET);
    assign op_redirect = op_is_mret || (issue_valid && (issue_op == gc_pkg::OP_FENCE_I));
    assign op_sfence   = issue_valid && (issue_op == gc_pkg::OP_SFENCE);

    assign pipe_empty = (inflight_count == '0);

    // States where a trap or interrupt may be taken
    assign trap_window = (state == gc_pkg::ST_IDLE) || (state == gc_pkg::ST_DRAIN);

    // Oldest instruction has a matching exception
    assign trap_valid = sel_valid && !pipe_empty && trap_window;

    // Nothing left in flight, safe to redirect
    assign interrupt_taken = interrupt_pending && pipe_empty && trap_window;

    //////////////////////////////
    // State machine

    always_ff @(posedge clk) begin
        if (rst)
            state <= gc_pkg::ST_RESET;
        else
            state <= next_state;
    end

    always_comb begin
        next_state = state;
        case (state)
            gc_pkg::ST_RESET:      next_state = gc_pkg::ST_PRE_CLEAR;
            gc_pkg::ST_PRE_CLEAR:  next_state = gc_pkg::ST_INIT_CLEAR;
            gc_pkg::ST_INIT_CLEAR: begin
                if (init_clear_done)
                    next_state = gc_pkg::ST_IDLE;
            end
            gc_pkg::ST_IDLE: begin
                // Trap beats everything else arriving the same cycle
                if (trap_valid)
                    next_state = gc_pkg::ST_DISCARD;
                else if (op_redirect || interrupt_pending)
                    next_state = gc_pkg::ST_DRAIN;
                else if (op_sfence)
                    next_state = gc_pkg::ST_TLB_CLEAR;
            end
            gc_pkg::ST_TLB_CLEAR: begin
                if (tlb_clear_done)
                    next_state = gc_pkg::ST_IDLE;
            end
            gc_pkg::ST_DRAIN: begin
                if (pipe_empty)
                    next_state = gc_pkg::ST_IDLE;
                else if (trap_valid)
                    next_state = gc_pkg::ST_DISCARD;
            end
            // Younger instructions retire with writeback blocked
            gc_pkg::ST_DISCARD: begin
                if (pipe_empty)
                    next_state = gc_pkg::ST_IDLE;
            end
            default: next_state = gc_pkg::ST_RESET;
        endcase
    end

    //////////////////////////////
    // Sweep counter

    // Shared by init and TLB sweeps, cleared on the way back to IDLE
    always_ff @(posedge clk) begin
        if (rst || next_state == gc_pkg::ST_IDLE)
            clear_cnt <= '0;
        else if (next_state inside {gc_pkg::ST_INIT_CLEAR, gc_pkg::ST_TLB_CLEAR})
            clear_cnt <= clear_cnt + 1'b1;
    end

    // Depths are powers of two, one bit marks the end
    assign init_clear_done = clear_cnt[$clog2(INIT_CLEAR_DEPTH)];
    assign tlb_clear_done  = clear_cnt[$clog2(TLB_CLEAR_DEPTH)];

    //////////////////////////////
    // Registered controls

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_hold         <= 1'b1;
            issue_hold         <= 1'b1;
            init_clear         <= 1'b0;
            tlb_flush          <= 1'b0;
            suppress_writeback <= 1'b0;
            pc_override        <= 1'b0;
            exc_ack            <= 1'b0;
            mret               <= 1'b0;
        end else begin
            // Interrupt redirect cycle stays held even when leaving DRAIN
            fetch_hold <= interrupt_taken ||
                          next_state inside {gc_pkg::ST_PRE_CLEAR, gc_pkg::ST_INIT_CLEAR,
                                             gc_pkg::ST_DRAIN};
            issue_hold <= interrupt_taken ||
                          next_state inside {gc_pkg::ST_PRE_CLEAR, gc_pkg::ST_INIT_CLEAR,
                                             gc_pkg::ST_TLB_CLEAR, gc_pkg::ST_DRAIN,
                                             gc_pkg::ST_DISCARD};
            suppress_writeback <= next_state inside {gc_pkg::ST_PRE_CLEAR,
                                                     gc_pkg::ST_INIT_CLEAR,
                                                     gc_pkg::ST_DISCARD};
            init_clear <= next_state == gc_pkg::ST_INIT_CLEAR;
            tlb_flush  <= next_state == gc_pkg::ST_TLB_CLEAR;
            // Redirect one cycle after its cause
            pc_override <= op_redirect || trap_valid || interrupt_taken ||
                           (state == gc_pkg::ST_PRE_CLEAR);
            exc_ack <= trap_valid;
            // A trap or interrupt in the same cycle wins over the return
            mret <= op_is_mret && !trap_valid && !interrupt_taken;
        end
    end

    // Redirect target
    always_ff @(posedge clk) begin
        if (trap_valid || interrupt_taken)
            pc <= trap_vector;
        else if (state == gc_pkg::ST_PRE_CLEAR)
            pc <= RESET_VECTOR;
        else if (op_is_mret)
            pc <= epc;
        else
            pc <= issue_pc + INSTR_BYTES;
    end

    // Front end flushes whenever it is redirected
    assign fetch_flush = pc_override;

    //////////////////////////////
    // Checks

    // Every redirect cause is a single-cycle event
    pc_override_pulse_a: assert property (@(posedge clk) disable iff (rst)
        pc_override |=> !pc_override)
        else $error("pc_override high in two consecutive cycles");

endmodule

// ==== rtl/gc_top.sv ====
module gc_top #(
    parameter int                      NUM_EXC_SOURCES  = 2,
    parameter int                      INIT_CLEAR_DEPTH = 64,
    parameter int                      TLB_CLEAR_DEPTH  = 16,
    parameter logic [gc_pkg::XLEN-1:0] RESET_VECTOR     = 32'h0000_0100
) (
    input  logic                                          clk,
    input  logic                                          rst,
    // Issue and retire
    input  logic                                          issue_valid,
    input  gc_pkg::gc_op_t                                issue_op,
    input  logic [gc_pkg::XLEN-1:0]                       issue_pc,
    input  logic                                          retire,
    output logic [gc_pkg::ID_W-1:0]                       next_id,
    output logic [gc_pkg::ID_W-1:0]                       oldest_id,
    output logic [gc_pkg::ID_W:0]                         inflight_count,
    // Exception sources
    input  logic [NUM_EXC_SOURCES-1:0]                    exc_valid,
    input  gc_pkg::exc_code_t [NUM_EXC_SOURCES-1:0]       exc_code,
    input  logic [NUM_EXC_SOURCES-1:0][gc_pkg::ID_W-1:0]  exc_id,
    input  logic [NUM_EXC_SOURCES-1:0][gc_pkg::XLEN-1:0]  exc_tval,
    output logic                                          exc_ack,
    // CSR side
    input  logic [gc_pkg::XLEN-1:0]                       epc,
    input  logic [gc_pkg::XLEN-1:0]                       trap_vector,
    input  logic                                          interrupt_pending,
    output logic                                          interrupt_taken,
    output logic                                          mret,
    output logic                                          trap_valid,
    output gc_pkg::exc_code_t                             trap_code,
    output logic [gc_pkg::XLEN-1:0]                       trap_tval,
    output logic [gc_pkg::XLEN-1:0]                       trap_pc,
    // Pipeline controls
    output logic                                          fetch_hold,
    output logic                                          issue_hold,
    output logic                                          fetch_flush,
    output logic                                          pc_override,
    output logic [gc_pkg::XLEN-1:0]                       pc,
    output logic                                          init_clear,
    output logic                                          tlb_flush,
    output logic                                          suppress_writeback
);

    // Arbiter hit on the oldest id
    logic sel_valid;

    //////////////////////////////
    // Id tracking

    // Oldest PC doubles as the trap PC
    inflight_tracker u_tracker (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue_pc       (issue_pc),
        .retire         (retire),
        .next_id        (next_id),
        .oldest_id      (oldest_id),
        .oldest_pc      (trap_pc),
        .inflight_count (inflight_count)
    );

    //////////////////////////////
    // Exception selection

    exception_arbiter #(
        .NUM_EXC_SOURCES (NUM_EXC_SOURCES)
    ) u_arbiter (
        .clk       (clk),
        .rst       (rst),
        .exc_valid (exc_valid),
        .exc_code  (exc_code),
        .exc_id    (exc_id),
        .exc_tval  (exc_tval),
        .oldest_id (oldest_id),
        .exc_ack   (exc_ack),
        .sel_valid (sel_valid),
        .sel_code  (trap_code),
        .sel_tval  (trap_tval)
    );

    //////////////////////////////
    // Global control

    gc_unit #(
        .INIT_CLEAR_DEPTH (INIT_CLEAR_DEPTH),
        .TLB_CLEAR_DEPTH  (TLB_CLEAR_DEPTH),
        .RESET_VECTOR     (RESET_VECTOR)
    ) u_gc_unit (
        .clk                (clk),
        .rst                (rst),
        .issue_valid        (issue_valid),
        .issue_op           (issue_op),
        .issue_pc           (issue_pc),
        .epc                (epc),
        .trap_vector        (trap_vector),
        .inflight_count     (inflight_count),
        .interrupt_pending  (interrupt_pending),
        .sel_valid          (sel_valid),
        .fetch_hold         (fetch_hold),
        .issue_hold         (issue_hold),
        .fetch_flush        (fetch_flush),
        .pc_override        (pc_override),
        .pc                 (pc),
        .init_clear         (init_clear),
        .tlb_flush          (tlb_flush),
        .suppress_writeback (suppress_writeback),
        .trap_valid         (trap_valid),
        .exc_ack            (exc_ack),
        .mret               (mret),
        .interrupt_taken    (interrupt_taken)
    );

endmodule

// ==== tests/gc_tb.sv ====
module gc_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int                INIT_DEPTH = 64;
    localparam int                TLB_DEPTH  = 16;
    localparam logic [31:0]       RESET_VEC  = 32'h0000_0100;

    logic clk = 1'b0;
    logic rst;
    logic issue_valid;
    gc_pkg::gc_op_t issue_op;
    logic [31:0] issue_pc;
    logic retire;
    logic [2:0] next_id;
    logic [2:0] oldest_id;
    logic [3:0] inflight_count;
    logic [1:0] exc_valid;
    gc_pkg::exc_code_t [1:0] exc_code;
    logic [1:0][2:0] exc_id;
    logic [1:0][31:0] exc_tval;
    logic exc_ack;
    logic [31:0] epc;
    logic [31:0] trap_vector;
    logic interrupt_pending;
    logic interrupt_taken;
    logic mret;
    logic trap_valid;
    gc_pkg::exc_code_t trap_code;
    logic [31:0] trap_tval;
    logic [31:0] trap_pc;
    logic fetch_hold;
    logic issue_hold;
    logic fetch_flush;
    logic pc_override;
    logic [31:0] pc;
    logic init_clear;
    logic tlb_flush;
    logic suppress_writeback;

    // Model of the ids and PCs in flight, oldest first
    logic [2:0]  q_id[$];
    logic [31:0] q_pc[$];
    logic [2:0]  model_next = '0;

    // Expected redirect from the previous cycle
    logic        exp_ovr = 1'b0;
    logic [31:0] exp_pc = '0;
    logic        exp_mret = 1'b0;
    logic        exp_ack = 1'b0;
    logic        ack_seen = 1'b0;
    logic        int_seen = 1'b0;
    logic        drain_chk = 1'b0;
    logic        discard_chk = 1'b0;
    int          tlb_left = 0;

    int          check_errors = 0;
    int          timeout_errors = 0;
    logic [31:0] lfsr_state = 32'h897979c6;

    gc_top #(
        .NUM_EXC_SOURCES  (2),
        .INIT_CLEAR_DEPTH (INIT_DEPTH),
        .TLB_CLEAR_DEPTH  (TLB_DEPTH),
        .RESET_VECTOR     (RESET_VEC)
    ) i_gc_top (.*);

    always #4 clk = ~clk;

    ////////////////////////////////
    // Helpers

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            v = {v[30:0], lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return v;
    endfunction

    function automatic gc_pkg::exc_code_t pick_code(input logic [31:0] r);
        case (r % 5)
            0: return gc_pkg::EXC_INSTR_MISALIGNED;
            1: return gc_pkg::EXC_ILLEGAL;
            2: return gc_pkg::EXC_ECALL;
            3: return gc_pkg::EXC_LOAD_MISALIGNED;
            default: return gc_pkg::EXC_STORE_MISALIGNED;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            check_errors++;
        end
    endtask

    ////////////////////////////////
    // One random cycle

    task automatic run_cycle(input bit allow_new);
        int   k;
        int   hit;
        logic blocked;
        logic redirect_op;
        // Inputs change on the falling edge
        @(negedge clk);
        // Sources drop their exceptions after the ack
        if (ack_seen)
            exc_valid = '0;
        if (int_seen)
            interrupt_pending = 1'b0;
        ack_seen    = 1'b0;
        int_seen    = 1'b0;
        issue_valid = 1'b0;
        retire      = 1'b0;
        epc         = rand_bits(30) << 2;
        trap_vector = rand_bits(30) << 2;
        if (allow_new && !interrupt_pending && rand_bits(6) == 0)
            interrupt_pending = 1'b1;
        // Raise only in IDLE, against an id in flight
        for (int i = 0; i < 2; i++) begin
            if (allow_new && !exc_valid[i] && !issue_hold && q_id.size() > 0
                && rand_bits(4) == 0) begin
                k = int'(rand_bits(3)) % q_id.size();
                exc_id[i]   = q_id[k];
                exc_code[i] = pick_code(rand_bits(3));
                exc_tval[i] = rand_bits(32);
                exc_valid[i] = 1'b1;
            end
        end
        if (allow_new && !issue_hold && !interrupt_pending && q_id.size() < 8
            && rand_bits(1) == 1) begin
            issue_valid = 1'b1;
            case (rand_bits(3))
                5: issue_op = gc_pkg::OP_FENCE_I;
                6: issue_op = gc_pkg::OP_MRET;
                7: issue_op = gc_pkg::OP_SFENCE;
                default: issue_op = gc_pkg::OP_NORMAL;
            endcase
            issue_pc = rand_bits(30) << 2;
        end
        redirect_op = issue_valid && (issue_op == gc_pkg::OP_FENCE_I ||
                                      issue_op == gc_pkg::OP_MRET);
        // Excepting oldest never retires, nor does anything beside a redirect
        blocked = 1'b0;
        for (int i = 0; i < 2; i++)
            if (q_id.size() > 0 && exc_valid[i] && exc_id[i] == q_id[0])
                blocked = 1'b1;
        if (q_id.size() > 0 && !blocked && !redirect_op && rand_bits(1) == 1)
            retire = 1'b1;

        // Sample just before the rising edge
        #3;
        check_value(32'(pc_override), 32'(exp_ovr), "pc_override");
        check_value(32'(fetch_flush), 32'(exp_ovr), "fetch_flush");
        if (exp_ovr)
            check_value(pc, exp_pc, "redirect pc");
        check_value(32'(mret), 32'(exp_ovr && exp_mret), "mret");
        check_value(32'(exc_ack), 32'(exp_ack), "exc_ack");
        // Tracker state against the model queue
        check_value(32'(inflight_count), 32'(q_id.size()), "inflight_count");
        if (q_id.size() > 0)
            check_value(32'(oldest_id), 32'(q_id[0]), "oldest_id");
        else
            check_value(32'(oldest_id), 32'(model_next), "oldest_id when empty");
        check_value(32'(init_clear), 32'd0, "init_clear after init");
        check_value(32'(tlb_flush), 32'(tlb_left > 0), "tlb_flush");
        if (tlb_left > 0)
            tlb_left--;
        check_value(32'(interrupt_taken && q_id.size() != 0), 32'd0,
                    "interrupt_taken with instructions in flight");
        if (drain_chk) begin
            if (q_id.size() > 0)
                check_value(32'(issue_hold), 32'd1, "issue_hold during drain");
            else
                drain_chk = 1'b0;
        end
        if (discard_chk) begin
            if (q_id.size() > 0) begin
                check_value(32'(suppress_writeback), 32'd1, "suppress_writeback in discard");
                check_value(32'(issue_hold), 32'd1, "issue_hold in discard");
            end else begin
                discard_chk = 1'b0;
            end
        end
        // Lowest source on the oldest id
        hit = -1;
        for (int i = 1; i >= 0; i--)
            if (q_id.size() > 0 && exc_valid[i] && exc_id[i] == q_id[0])
                hit = i;
        if (trap_valid) begin
            if (hit < 0) begin
                check_value(32'(trap_valid), 32'd0, "trap without exception on oldest id");
            end else begin
                check_value(32'(trap_code), 32'(exc_code[hit]), "trap_code");
                check_value(trap_tval, exc_tval[hit], "trap_tval");
                check_value(trap_pc, q_pc[0], "trap_pc");
            end
        end
        if (issue_valid)
            check_value(32'(next_id), 32'(model_next), "next_id");

        // Expected effects one cycle later
        exp_ovr  = trap_valid || interrupt_taken || redirect_op;
        exp_mret = issue_valid && issue_op == gc_pkg::OP_MRET && !trap_valid
                   && !interrupt_taken;
        exp_ack  = trap_valid;
        if (trap_valid || interrupt_taken)
            exp_pc = trap_vector;
        else if (issue_op == gc_pkg::OP_MRET)
            exp_pc = epc;
        else
            exp_pc = issue_pc + 32'd4;
        ack_seen = exc_ack;
        int_seen = interrupt_taken;
        if (trap_valid)
            discard_chk = 1'b1;
        else if (redirect_op)
            drain_chk = 1'b1;
        else if (issue_valid && issue_op == gc_pkg::OP_SFENCE)
            tlb_left = TLB_DEPTH;
        if (retire) begin
            void'(q_id.pop_front());
            void'(q_pc.pop_front());
        end
        if (issue_valid) begin
            q_id.push_back(model_next);
            q_pc.push_back(issue_pc);
            model_next = model_next + 3'd1;
        end
    endtask

    ////////////////////////////////
    // Main sequence

    initial begin
        int  init_cycles;
        bit  ovr_seen;
        bit  done;
        rst = 1'b1;
        issue_valid = 1'b0;
        issue_op = gc_pkg::OP_NORMAL;
        issue_pc = '0;
        retire = 1'b0;
        exc_valid = '0;
        exc_code[0] = gc_pkg::EXC_ILLEGAL;
        exc_code[1] = gc_pkg::EXC_ILLEGAL;
        exc_id = '0;
        exc_tval = '0;
        epc = '0;
        trap_vector = '0;
        interrupt_pending = 1'b0;
        init_cycles = 0;
        ovr_seen = 1'b0;
        done = 1'b0;
        repeat (8) @(negedge clk);
        // Holds up, everything else quiet in reset
        check_value(32'(issue_hold), 32'd1, "issue_hold in reset");
        check_value(32'(fetch_hold), 32'd1, "fetch_hold in reset");
        check_value(32'(pc_override), 32'd0, "pc_override in reset");
        check_value(32'(init_clear), 32'd0, "init_clear in reset");
        rst = 1'b0;

        // Power-on sweep until issue opens
        for (int c = 0; c < 300 && !done; c++) begin
            @(negedge clk);
            #3;
            if (pc_override && !ovr_seen) begin
                ovr_seen = 1'b1;
                check_value(pc, RESET_VEC, "reset vector");
            end
            if (init_clear) begin
                init_cycles++;
                check_value(32'(issue_hold), 32'd1, "issue_hold during init clear");
            end
            if (!issue_hold)
                done = 1'b1;
        end
        if (!done) begin
            $display("Timeout: issue_hold never fell after the init clear");
            timeout_errors++;
        end
        check_value(32'(init_cycles), 32'(INIT_DEPTH), "init_clear length");
        check_value(32'(ovr_seen), 32'd1, "pc_override at init");

        repeat (4000) run_cycle(1'b1);

        // Let everything in flight finish
        done = 1'b0;
        for (int c = 0; c < 1000 && !done; c++) begin
            run_cycle(1'b0);
            if (q_id.size() == 0 && !issue_hold && !interrupt_pending
                && exc_valid == '0 && tlb_left == 0)
                done = 1'b1;
        end
        if (!done) begin
            $display("Timeout: pipeline did not drain at the end of the run");
            timeout_errors++;
        end

        $display("Check failures: %0d, timeouts: %0d", check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/gc_pkg.sv
rtl/inflight_tracker.sv
rtl/exception_arbiter.sv
rtl/gc_unit.sv
rtl/gc_top.sv
tests/gc_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the control block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module gc_tb -o gc_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/gc_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "No errors" <<< "$output"; then
    exit 0
fi
exit 1
